//--- rtl/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

//******************************
// fetch stage build settings
//******************************

// boot address
// first fetch after reset comes from here
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// instruction memory geometry
// depth counted in 64-bit words, two instructions per word
`define FETCH_MEM_WORDS 64

// word address width, log2 of the depth
// keep in step with FETCH_MEM_WORDS
`define FETCH_MEM_AW 6

`endif

//--- rtl/rv_inst_pkg.sv
package rv_inst_pkg;

	//******************************
	// rv64 encodings seen by fetch
	//******************************

	// major opcodes that can move pc away from pc+4
	typedef enum logic [6:0] {
		op_branch = 7'b1100011, // beq .. bgeu
		op_jalr   = 7'b1100111,
		op_jal    = 7'b1101111,
		op_system = 7'b1110011  // ecall, ebreak, csr*, mret
	} rv_opcode_e;

	// funct3 of the conditional branches
	// 3'b010 and 3'b011 are not branches
	typedef enum logic [2:0] {
		f3_beq  = 3'b000,
		f3_bne  = 3'b001,
		f3_blt  = 3'b100,
		f3_bge  = 3'b101,
		f3_bltu = 3'b110,
		f3_bgeu = 3'b111
	} rv_funct3_e;

	localparam logic [2:0] F3_JALR = 3'b000; // only legal jalr funct3

	// I-format layout, msb first
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_itype_t;

	// one instruction word, read whole or by fields
	typedef union packed {
		logic [31:0] raw; // whole-word compares
		rv_itype_t   f;   // opcode / funct3 decode
	} rv_inst_t;

	// full-word system instructions
	localparam logic [31:0] ECALL_WORD = {12'h000, 5'd0, 3'b000, 5'd0, op_system};
	localparam logic [31:0] MRET_WORD  = {12'h302, 5'd0, 3'b000, 5'd0, op_system};

	// control-flow class of the word at pc
	typedef struct packed {
		logic is_branch; // bxx or jalr
		logic is_jal;
		logic is_sys;    // ecall or mret
	} cf_class_t;

endpackage

//--- rtl/fetch_ctrl_pkg.sv
`include "fetch_settings.svh"

package fetch_ctrl_pkg;
	import rv_inst_pkg::*;

	//******************************
	// fetch control types
	//******************************

	typedef enum logic [1:0] {
		fs_run           = 2'b00, // handing words to decode
		fs_wait_redirect = 2'b01  // parked on a control-flow word
	} fetch_state_e;

	// what pc does on the next edge
	typedef enum logic [1:0] {
		pc_hold = 2'b00,
		pc_step = 2'b01, // pc + 4
		pc_load = 2'b10  // pc <= dnpc
	} pc_cmd_e;

	// from execute
	typedef struct packed {
		logic        pc_update; // one-cycle strobe
		logic [63:0] dnpc;      // resolved next pc
	} redirect_t;

	// to decode
	typedef struct packed {
		logic        valid;
		logic [63:0] pc;
		rv_inst_t    inst;
	} fetch_out_t;

	// loader write port into instruction memory
	typedef struct packed {
		logic                     en;
		logic [`FETCH_MEM_AW-1:0] addr; // 64-bit word address
		logic [63:0]              data;
	} imem_wr_t;

endpackage

//--- rtl/ctrl_flow_detect.sv
`timescale 1ns/1ps

module ctrl_flow_detect import rv_inst_pkg::*; (
	input  rv_inst_t  inst,
	output cf_class_t cf
);

	//******************************
	// field view decode
	//******************************

	logic is_bxx;  // conditional branch
	logic is_jalr;

	always_comb begin
		is_bxx = 1'b0;
		if (inst.f.opcode == op_branch) begin
			case (inst.f.funct3)
				f3_beq, f3_bne: is_bxx = 1'b1;
				f3_blt, f3_bge: is_bxx = 1'b1;
				f3_bltu, f3_bgeu: is_bxx = 1'b1;
				default: is_bxx = 1'b0; // 010 / 011 reserved
			endcase
		end
	end

	// jalr with any other funct3 is not a real jalr
	assign is_jalr = (inst.f.opcode == op_jalr) && (inst.f.funct3 == F3_JALR);

	//******************************
	// class flags
	//******************************

	always_comb begin
		cf = '0;
		cf.is_branch = is_bxx | is_jalr; // target known only in execute
		cf.is_jal = (inst.f.opcode == op_jal); // opcode alone
		// raw view here
		// other system words (csr ops, ebreak) flow through
		cf.is_sys = (inst.raw == ECALL_WORD) || (inst.raw == MRET_WORD);
	end

endmodule

//--- rtl/fetch_fsm.sv
`timescale 1ns/1ps

module fetch_fsm import rv_inst_pkg::*, fetch_ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  cf_class_t cf,        // class of word at pc
	input  logic      ready,     // decode can take a word
	input  logic      pc_update, // execute strobe
	output logic      valid,     // word at pc offered to decode
	output pc_cmd_e   cmd        // applied by pc_counter next edge
);

	fetch_state_e state;
	fetch_state_e state_nxt;
	logic         cf_hit; // any control-flow flag

	assign cf_hit = |cf;

	//******************************
	// state register
	//******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fs_run;
		end else begin
			state <= state_nxt;
		end
	end

	//******************************
	// next state, valid, pc command
	//******************************

	always_comb begin
		state_nxt = state;
		valid     = 1'b1;
		cmd       = pc_hold;
		case (state)
			fs_run: begin
				valid = 1'b1;
				if (cf_hit && pc_update) begin
					// redirect already here, no bubble
					cmd = pc_load;
				end else if (cf_hit) begin
					cmd = pc_hold; // wait for execute
					if (ready) begin
						state_nxt = fs_wait_redirect; // decode took it
					end
				end else if (ready) begin
					cmd = pc_step; // straight-line code
				end else begin
					cmd = pc_hold; // back-pressure
				end
			end
			fs_wait_redirect: begin
				valid = 1'b0; // word already handed off
				if (pc_update) begin
					cmd       = pc_load;
					state_nxt = fs_run;
				end
			end
			default: begin
				// unused encodings fall back to run
				state_nxt = fs_run;
			end
		endcase
	end

endmodule

//--- rtl/pc_counter.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pc_counter import fetch_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  pc_cmd_e     cmd,
	input  logic [63:0] dnpc,        // redirect target
	input  logic        handoff,     // valid & ready this cycle
	output logic [63:0] pc,
	output logic [31:0] fetch_count  // words taken by decode
);

	//******************************
	// program counter
	//******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `FETCH_RESET_PC; // boot address
		end else begin
			case (cmd)
				pc_step: pc <= pc + 64'd4;
				pc_load: pc <= dnpc;
				default: pc <= pc; // pc_hold
			endcase
		end
	end

	//******************************
	// handoff counter
	//******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_count <= 32'd0;
		end else if (handoff) begin
			fetch_count <= fetch_count + 32'd1; // wraps at 2^32
		end
	end

endmodule

//--- rtl/inst_mem.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_mem import rv_inst_pkg::*, fetch_ctrl_pkg::*; (
	input  logic        clk,
	input  imem_wr_t    wr,   // loader port
	input  logic [63:0] pc,
	output rv_inst_t    inst
);

	localparam int WORDS = `FETCH_MEM_WORDS;
	localparam int AW    = `FETCH_MEM_AW;

	logic [63:0]   mem [WORDS]; // two instructions per entry
	logic [AW-1:0] rd_idx;
	logic [AW-1:0] wr_idx;
	logic [63:0]   rd_word;

	//******************************
	// address mapping
	//******************************

	// pc[2:0] picks the byte inside a word
	// the rest wraps onto the array
	assign rd_idx = AW'(pc[63:3] % WORDS);
	assign wr_idx = AW'(wr.addr % WORDS);

	//******************************
	// write port
	//******************************

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr_idx] <= wr.data; // seen by reads after this edge
		end
	end

	//******************************
	// read port
	//******************************

	assign rd_word = mem[rd_idx]; // async read
	assign inst    = pc[2] ? rd_word[63:32] : rd_word[31:0]; // little endian halves

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_inst_pkg::*, fetch_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        ready,       // from decode
	input  redirect_t   redir,       // from execute
	input  imem_wr_t    imem_wr,     // from loader
	output fetch_out_t  fetch,       // to decode
	output logic [31:0] fetch_count
);

	logic [63:0] pc;
	rv_inst_t    inst;
	cf_class_t   cf;
	logic        valid;
	pc_cmd_e     cmd;
	logic        handoff;

	// the one piece of glue logic
	assign handoff = valid & ready;

	//******************************
	// datapath
	//******************************

	inst_mem u_inst_mem (
		.clk  (clk),
		.wr   (imem_wr),
		.pc   (pc),
		.inst (inst)
	);

	ctrl_flow_detect u_cf_detect (
		.inst (inst),
		.cf   (cf)
	);

	//******************************
	// control
	//******************************

	fetch_fsm u_fetch_fsm (
		.clk       (clk),
		.rst       (rst),
		.cf        (cf),
		.ready     (ready),
		.pc_update (redir.pc_update),
		.valid     (valid),
		.cmd       (cmd)
	);

	pc_counter u_pc_counter (
		.clk         (clk),
		.rst         (rst),
		.cmd         (cmd),
		.dnpc        (redir.dnpc),
		.handoff     (handoff),
		.pc          (pc),
		.fetch_count (fetch_count)
	);

	// bundle for decode
	assign fetch = '{valid: valid, pc: pc, inst: inst};

endmodule

//--- verification/fetch_unit_assert.sv
`timescale 1ns/1ps

module fetch_unit_assert import fetch_ctrl_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       ready,
	input redirect_t  redir,
	input fetch_out_t fetch
);

	int fail_count = 0; // failed properties so far

	//******************************
	// fetch invariants
	//******************************

	pc_aligned: assert property (@(posedge clk) disable iff (rst) fetch.pc[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("pc lost 4-byte alignment");
		end

	// fs_run right out of reset
	valid_after_reset: assert property (@(posedge clk) $fell(rst) |-> fetch.valid)
		else begin
			fail_count++;
			$error("valid low in first cycle after reset");
		end

	pc_held: assert property (@(posedge clk) disable iff (rst)
		(!ready && !redir.pc_update) |=> $stable(fetch.pc))
		else begin
			fail_count++;
			$error("pc moved under back-pressure");
		end

	// only a redirect ends the bubble
	bubble_held: assert property (@(posedge clk) disable iff (rst)
		(!fetch.valid && !redir.pc_update) |=> !fetch.valid)
		else begin
			fail_count++;
			$error("valid rose without pc_update");
		end

endmodule

//--- verification/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_unit_tb import rv_inst_pkg::*, fetch_ctrl_pkg::*; ();

	logic        clk;
	logic        rst;
	logic        ready;
	redirect_t   redir;
	imem_wr_t    imem_wr;
	fetch_out_t  fetch;
	logic [31:0] fetch_count;

	logic [63:0] mem_img [`FETCH_MEM_WORDS]; // mirror of the instruction memory
	logic [63:0] exp_pc;
	logic        exp_wait;  // model parked on a control-flow word
	logic [31:0] exp_count;
	logic [31:0] lfsr_q;
	int          mismatches;
	int          timeouts;
	int          assert_fails;

	fetch_unit u_fetch_unit (
		.clk         (clk),
		.rst         (rst),
		.ready       (ready),
		.redir       (redir),
		.imem_wr     (imem_wr),
		.fetch       (fetch),
		.fetch_count (fetch_count)
	);

	bind fetch_unit fetch_unit_assert u_fetch_assert (.*);

	initial clk = 1'b0;
	always #2 clk = ~clk; // 4 ns period

	//******************************
	// stimulus helpers
	//******************************

	// 32-bit fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r = {r[30:0], fb}; // one step per bit
		end
		return r;
	endfunction

	// addi rd, x0, imm
	function automatic logic [31:0] filler();
		logic [4:0]  rd;
		logic [11:0] imm;
		rd = 5'(lfsr_bits(5));
		imm = 12'(lfsr_bits(12));
		return {imm, 5'd0, 3'b000, rd, 7'b0010011};
	endfunction

	// random operand fields around a fixed opcode and funct3
	function automatic logic [31:0] cf_word(input logic [6:0] opc, input logic [2:0] f3);
		return {17'(lfsr_bits(17)), f3, 5'(lfsr_bits(5)), opc};
	endfunction

	function automatic logic [`FETCH_MEM_AW-1:0] slot_of(input logic [63:0] pc);
		return `FETCH_MEM_AW'((pc >> 3) % `FETCH_MEM_WORDS);
	endfunction

	function automatic logic [31:0] inst_at(input logic [63:0] pc);
		logic [63:0] w;
		w = mem_img[slot_of(pc)];
		return pc[2] ? w[63:32] : w[31:0]; // bit 2 picks the half
	endfunction

	// jal, jalr, six branches, ecall, mret
	function automatic logic is_cf(input logic [31:0] w);
		logic [6:0] opc;
		logic [2:0] f3;
		opc = w[6:0];
		f3 = w[14:12];
		if (opc == 7'b1101111) return 1'b1;
		if (opc == 7'b1100111) return f3 == 3'b000;
		if (opc == 7'b1100011) return (f3 != 3'b010) && (f3 != 3'b011);
		return (w == ECALL_WORD) || (w == MRET_WORD);
	endfunction

	// write is applied on the next edge
	task automatic set_slot(input logic [63:0] pc, input logic [31:0] w);
		logic [63:0] d;
		d = mem_img[slot_of(pc)];
		if (pc[2]) begin
			d[63:32] = w;
		end else begin
			d[31:0] = w;
		end
		imem_wr = '{en: 1'b1, addr: slot_of(pc), data: d};
	endtask

	task automatic report_diff(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		mismatches++;
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
	endtask

	//******************************
	// reference model
	//******************************

	task automatic model_step();
		logic cf;
		cf = is_cf(inst_at(exp_pc)); // word before any write lands
		if (rst) begin
			exp_pc = `FETCH_RESET_PC;
			exp_wait = 1'b0;
			exp_count = 32'd0;
		end else if (!exp_wait) begin
			if (ready) exp_count = exp_count + 32'd1; // valid is high here
			if (cf && redir.pc_update) begin
				exp_pc = redir.dnpc;
			end else if (cf) begin
				exp_wait = ready;
			end else if (ready) begin
				exp_pc = exp_pc + 64'd4;
			end
		end else if (redir.pc_update) begin
			exp_pc = redir.dnpc;
			exp_wait = 1'b0;
		end
		if (imem_wr.en) mem_img[imem_wr.addr] = imem_wr.data;
	endtask

	// check mid-cycle and step the model up to the next falling edge
	task automatic cycle();
		#1;
		if (!rst) begin
			if (fetch.valid !== !exp_wait)
				report_diff("fetch.valid", 64'(fetch.valid), 64'(!exp_wait));
			if (fetch.pc !== exp_pc)
				report_diff("fetch.pc", fetch.pc, exp_pc);
			if (fetch.inst.raw !== inst_at(exp_pc))
				report_diff("fetch.inst", 64'(fetch.inst.raw), 64'(inst_at(exp_pc)));
			if (fetch_count !== exp_count)
				report_diff("fetch_count", 64'(fetch_count), 64'(exp_count));
		end
		model_step();
		@(negedge clk);
	endtask

	task automatic wait_valid(input logic level, input int limit);
		int n;
		n = 0;
		while (fetch.valid !== level && n < limit) begin
			cycle();
			n++;
		end
		if (fetch.valid !== level) begin
			timeouts++;
			$display("timeout at %0t: valid never reached %0b within %0d cycles",
				$time, level, limit);
		end
	endtask

	//******************************
	// directed tests
	//******************************

	// cf word at pc with optional ready-low hold and a delayed redirect
	task automatic stall_redirect(input logic [31:0] w, input int hold);
		logic [63:0] target;
		int          delay;
		target = `FETCH_RESET_PC + 64'(lfsr_bits(7)) * 64'd4;
		delay = int'(lfsr_bits(3)) + 1;
		ready = 1'b0;
		set_slot(exp_pc, w);
		cycle();
		imem_wr.en = 1'b0;
		repeat (hold) cycle(); // valid high and pc held
		ready = 1'b1;
		set_slot(exp_pc, filler()); // decode takes it while the slot reverts
		cycle();
		imem_wr.en = 1'b0;
		wait_valid(1'b0, 2);
		repeat (delay) cycle();
		redir = '{pc_update: 1'b1, dnpc: target};
		cycle();
		redir.pc_update = 1'b0;
		if (fetch.pc !== target) report_diff("fetch.pc", fetch.pc, target);
		if (fetch.valid !== 1'b1) report_diff("fetch.valid", 64'(fetch.valid), 64'd1);
	endtask

	task automatic reset_and_stream();
		if (fetch.pc !== `FETCH_RESET_PC)
			report_diff("fetch.pc", fetch.pc, `FETCH_RESET_PC);
		if (fetch.valid !== 1'b1) report_diff("fetch.valid", 64'(fetch.valid), 64'd1);
		if (fetch_count !== 32'd0) report_diff("fetch_count", 64'(fetch_count), 64'd0);
		ready = 1'b1;
		repeat (24) cycle();
		if (fetch.pc !== `FETCH_RESET_PC + 64'd96)
			report_diff("fetch.pc", fetch.pc, `FETCH_RESET_PC + 64'd96);
	endtask

	task automatic hold_under_backpressure();
		logic [63:0] pc0;
		logic [31:0] cnt0;
		int          n;
		n = int'(lfsr_bits(4)) + 2;
		ready = 1'b0;
		pc0 = exp_pc;
		cnt0 = exp_count;
		repeat (n) cycle();
		if (fetch.pc !== pc0) report_diff("fetch.pc", fetch.pc, pc0);
		if (fetch_count !== cnt0) report_diff("fetch_count", 64'(fetch_count), 64'(cnt0));
		ready = 1'b1;
		repeat (4) cycle();
	endtask

	task automatic branch_forms();
		logic [2:0] forms [6];
		forms = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		foreach (forms[i]) stall_redirect(cf_word(7'b1100011, forms[i]), 0);
		stall_redirect(cf_word(7'b1100111, 3'b000), 0); // jalr
	endtask

	task automatic jal_and_system();
		stall_redirect(cf_word(7'b1101111, 3'(lfsr_bits(3))), 0);
		stall_redirect(ECALL_WORD, 0);
		stall_redirect(MRET_WORD, 0);
		ready = 1'b0;
		set_slot(exp_pc, 32'h0010_0073); // ebreak flows through
		cycle();
		imem_wr.en = 1'b0;
		ready = 1'b1;
		repeat (2) cycle();
		if (fetch.valid !== 1'b1) report_diff("fetch.valid", 64'(fetch.valid), 64'd1);
	endtask

	task automatic same_cycle_redirect();
		logic [63:0] target;
		target = `FETCH_RESET_PC + 64'(lfsr_bits(7)) * 64'd4;
		ready = 1'b0;
		set_slot(exp_pc, cf_word(7'b1100011, 3'b000));
		cycle();
		ready = 1'b1;
		set_slot(exp_pc, filler());
		redir = '{pc_update: 1'b1, dnpc: target}; // strobe meets the branch
		cycle();
		imem_wr.en = 1'b0;
		redir.pc_update = 1'b0;
		if (fetch.pc !== target) report_diff("fetch.pc", fetch.pc, target);
		if (fetch.valid !== 1'b1) report_diff("fetch.valid", 64'(fetch.valid), 64'd1);
		redir = '{pc_update: 1'b1, dnpc: target ^ 64'h40}; // ignored with no cf word at pc
		cycle();
		redir.pc_update = 1'b0;
		if (fetch.pc !== target + 64'd4)
			report_diff("fetch.pc", fetch.pc, target + 64'd4);
	endtask

	//******************************
	// main sequence
	//******************************

	initial begin
		lfsr_q = 32'h5fd;
		mismatches = 0;
		timeouts = 0;
		assert_fails = 0;
		rst = 1'b1;
		ready = 1'b0;
		redir = '0;
		imem_wr = '0;
		exp_pc = `FETCH_RESET_PC;
		exp_wait = 1'b0;
		exp_count = 32'd0;
		@(negedge clk);
		for (int a = 0; a < `FETCH_MEM_WORDS; a++) begin
			imem_wr = '{en: 1'b1, addr: `FETCH_MEM_AW'(a), data: {filler(), filler()}};
			cycle();
		end
		imem_wr.en = 1'b0;
		repeat (4) cycle(); // four more reset cycles after the load
		rst = 1'b0;
		reset_and_stream();
		hold_under_backpressure();
		branch_forms();
		jal_and_system();
		same_cycle_redirect();
		stall_redirect(cf_word(7'b1100011, 3'b001), int'(lfsr_bits(3)) + 1);
		repeat (4) cycle();
		assert_fails = u_fetch_unit.u_fetch_assert.fail_count;
		$display("mismatches: %0d  timeouts: %0d  assertion failures: %0d",
			mismatches, timeouts, assert_fails);
		if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+rtl
rtl/rv_inst_pkg.sv
rtl/fetch_ctrl_pkg.sv
rtl/ctrl_flow_detect.sv
rtl/fetch_fsm.sv
rtl/pc_counter.sv
rtl/inst_mem.sv
rtl/fetch_unit.sv
verification/fetch_unit_assert.sv
verification/fetch_unit_tb.sv

//--- Makefile
SIM      := verilator
TOP      := fetch_unit_tb
FLIST    := flist.f
FLAGS    := --binary --timing --assert -j 0
RUN_ARGS := +verilator+error+limit+100
BUILD    := obj_dir
LOG      := sim.log

SRCS := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard rtl/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
